/* common/exec_pkg.sv */
`default_nettype none

package exec_pkg;

	// data path
	localparam int XLEN = 64;
	// word ops work on the low half
	localparam int WORD_W = 32;

	// register file
	localparam int REG_ADDR_W = 5;
	localparam int NUM_GPR = 32;

	// data ram, 256 bytes as double words
	localparam int DMEM_ADDR_W = 8;
	localparam int DMEM_WORDS = 32;
	localparam int STRB_W = 8;
	// byte offset inside one double word
	localparam int OFFS_W = 3;

	// shift amounts
	localparam int SHAMT_W = 6;
	localparam int SHAMTW_W = 5;

	// decoded operation
	typedef enum logic [4:0] {
		NOP,
		// 64-bit alu
		ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
		// 32-bit word ops, result sign extended
		ADDW, SUBW, SLLW, SRLW, SRAW,
		// loads
		LB, LH, LW, LBU, LHU, LWU, LD,
		// stores
		SB, SH, SW, SD
	} exec_op_t;

	// load class
	function automatic logic is_load(exec_op_t op);
		return op inside {LB, LH, LW, LBU, LHU, LWU, LD};
	endfunction

	// store class
	function automatic logic is_store(exec_op_t op);
		return op inside {SB, SH, SW, SD};
	endfunction

	// anything that writes the alu result to rd
	function automatic logic is_alu(exec_op_t op);
		return op inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
			ADDW, SUBW, SLLW, SRLW, SRAW};
	endfunction

endpackage

`default_nettype wire

/* rtl/alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit
	import exec_pkg::*;
(
	input  exec_op_t          op,
	input  logic [XLEN-1:0]   a,
	input  logic [XLEN-1:0]   b,
	output logic [XLEN-1:0]   result
);

	// shift amounts, 6 bits for 64-bit, 5 for word shifts
	logic [SHAMT_W-1:0]  shamt;
	logic [SHAMTW_W-1:0] shamt_w;
	// raw 32-bit result of a word op
	logic [WORD_W-1:0]   word_res;

	assign shamt = b[SHAMT_W-1:0];
	assign shamt_w = b[SHAMTW_W-1:0];

	// word ops first, only low halves take part
	always_comb begin
		case (op)
			ADDW: word_res = a[WORD_W-1:0] + b[WORD_W-1:0];
			SUBW: word_res = a[WORD_W-1:0] - b[WORD_W-1:0];
			SLLW: word_res = a[WORD_W-1:0] << shamt_w;
			SRLW: word_res = a[WORD_W-1:0] >> shamt_w;
			// arithmetic shift from bit 31, not bit 63
			SRAW: word_res = $signed(a[WORD_W-1:0]) >>> shamt_w;
			default: word_res = '0;
		endcase
	end

	always_comb begin
		case (op)
			ADD: result = a + b;
			SUB: result = a - b;
			AND: result = a & b;
			OR: result = a | b;
			XOR: result = a ^ b;
			SLL: result = a << shamt;
			SRL: result = a >> shamt;
			SRA: result = $signed(a) >>> shamt;
			// compares give 0 or 1
			SLT: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			SLTU: result = {{(XLEN-1){1'b0}}, a < b};
			// sign extend the 32-bit result
			ADDW, SUBW, SLLW, SRLW, SRAW: begin
				result = {{(XLEN-WORD_W){word_res[WORD_W-1]}}, word_res};
			end
			// memory ops: base plus offset is the byte address
			LB, LH, LW, LBU, LHU, LWU, LD,
			SB, SH, SW, SD: begin
				result = a + b;
			end
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* lsu/lsu_align.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_align
	import exec_pkg::*;
(
	// store side, same cycle as issue
	input  exec_op_t            st_op,
	input  logic [OFFS_W-1:0]   st_offs,
	input  logic [XLEN-1:0]     st_src,
	output logic [XLEN-1:0]     wdata,
	output logic [STRB_W-1:0]   wstrb,
	// load side, one cycle later with the ram read word
	input  exec_op_t            ld_op,
	input  logic [OFFS_W-1:0]   ld_offs,
	input  logic [XLEN-1:0]     rdata,
	output logic [XLEN-1:0]     load_data
);

	// strobe pattern before the lane shift
	logic [STRB_W-1:0] st_mask;
	// read word moved down so the addressed byte sits at bit 0
	logic [XLEN-1:0]   ld_shift;

	// access size from the opcode
	always_comb begin
		case (st_op)
			SB: st_mask = STRB_W'(8'h01);
			SH: st_mask = STRB_W'(8'h03);
			SW: st_mask = STRB_W'(8'h0f);
			SD: st_mask = '1;
			// not a store, nothing written
			default: st_mask = '0;
		endcase
	end

	// move mask and data up to the addressed lanes
	// lanes outside the mask carry junk, the strobes drop them
	assign wstrb = st_mask << st_offs;
	assign wdata = st_src << {st_offs, 3'b000};

	assign ld_shift = rdata >> {ld_offs, 3'b000};

	// pick the size and extend
	always_comb begin
		case (ld_op)
			LB: load_data = {{(XLEN-8){ld_shift[7]}}, ld_shift[7:0]};
			LH: load_data = {{(XLEN-16){ld_shift[15]}}, ld_shift[15:0]};
			LW: begin
				load_data = {{(XLEN-WORD_W){ld_shift[WORD_W-1]}}, ld_shift[WORD_W-1:0]};
			end
			// unsigned forms fill with zeros
			LBU: load_data = {{(XLEN-8){1'b0}}, ld_shift[7:0]};
			LHU: load_data = {{(XLEN-16){1'b0}}, ld_shift[15:0]};
			LWU: load_data = {{(XLEN-WORD_W){1'b0}}, ld_shift[WORD_W-1:0]};
			// double words are always at offset 0
			LD: load_data = rdata;
			default: load_data = '0;
		endcase
	end

endmodule

`default_nettype wire

/* lsu/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram
	import exec_pkg::*;
(
	input  logic                    clk,
	input  logic [DMEM_ADDR_W-1:0]  addr,
	input  logic [XLEN-1:0]         wdata,
	input  logic [STRB_W-1:0]       wstrb,
	output logic [XLEN-1:0]         rdata
);

	logic [XLEN-1:0] mem [DMEM_WORDS];
	// double word index, upper address bits
	logic [DMEM_ADDR_W-OFFS_W-1:0] idx;

	// byte offset is handled in lsu_align
	assign idx = addr[DMEM_ADDR_W-1:OFFS_W];

	// byte lanes written under strobe
	// read is registered and sees the old word on a same-cycle write
	always_ff @(posedge clk) begin
		for (int i = 0; i < STRB_W; i++) begin
			if (wstrb[i]) begin
				mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
			end
		end
		rdata <= mem[idx];
	end

endmodule

`default_nettype wire

/* rtl/gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_file
	import exec_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic [REG_ADDR_W-1:0]  rs1,
	input  logic [REG_ADDR_W-1:0]  rs2,
	input  logic                   wen,
	input  logic [REG_ADDR_W-1:0]  wr_rd,
	input  logic [XLEN-1:0]        wr_data,
	output logic [XLEN-1:0]        rs1_data,
	output logic [XLEN-1:0]        rs2_data
);

	logic [XLEN-1:0] regs [NUM_GPR];

	// x0 is never written, write back already blocks rd 0
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_GPR; i++) begin
				regs[i] <= '0;
			end
		end else if (wen) begin
			regs[wr_rd] <= wr_data;
		end
	end

	// write-through bypass
	// op right behind its producer gets the value being written this cycle
	assign rs1_data = (wen && wr_rd == rs1) ? wr_data : regs[rs1];
	assign rs2_data = (wen && wr_rd == rs2) ? wr_data : regs[rs2];

endmodule

`default_nettype wire

/* rtl/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage
	import exec_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	// from issue
	input  logic                   valid,
	input  exec_op_t               op,
	input  logic [REG_ADDR_W-1:0]  rd,
	input  logic [XLEN-1:0]        alu_result,
	input  logic [XLEN-1:0]        st_data,
	// from lsu_align load side
	input  logic [XLEN-1:0]        load_data,
	// back to lsu_align
	output exec_op_t               ex_op,
	output logic [OFFS_W-1:0]      ex_offs,
	// register file write port
	output logic                   gpr_wen,
	output logic [REG_ADDR_W-1:0]  gpr_rd,
	output logic [XLEN-1:0]        gpr_wdata,
	// retire report
	output logic                   retire_valid,
	output logic                   retire_wen,
	output logic [REG_ADDR_W-1:0]  retire_rd,
	output logic [XLEN-1:0]        retire_data
);

	logic                  ex_valid;
	logic [REG_ADDR_W-1:0] ex_rd;
	logic [XLEN-1:0]       ex_result;
	logic [XLEN-1:0]       ex_st_data;

	// execute to write-back register
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
			ex_op <= NOP;
		end else begin
			ex_valid <= valid;
			ex_op <= op;
		end
	end

	always_ff @(posedge clk) begin
		ex_rd <= rd;
		ex_result <= alu_result;
		ex_st_data <= st_data;
	end

	// low address bits pick the lanes of the ram word
	assign ex_offs = ex_result[OFFS_W-1:0];

	// loads take the aligned ram data, alu ops their result
	assign gpr_wdata = is_load(ex_op) ? load_data : ex_result;
	assign gpr_rd = ex_rd;
	// stores and nops write nothing, x0 stays zero
	assign gpr_wen = ex_valid && (is_alu(ex_op) || is_load(ex_op)) && ex_rd != '0;

	// retire flags
	always_ff @(posedge clk) begin
		if (rst) begin
			retire_valid <= 1'b0;
			retire_wen <= 1'b0;
		end else begin
			retire_valid <= ex_valid;
			retire_wen <= gpr_wen;
		end
	end

	// retire payload, store data for stores
	always_ff @(posedge clk) begin
		retire_rd <= ex_rd;
		retire_data <= is_store(ex_op) ? ex_st_data : gpr_wdata;
	end

endmodule

`default_nettype wire

/* rtl/rv_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core
	import exec_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_valid,
	input  exec_op_t               in_op,
	input  logic [REG_ADDR_W-1:0]  in_rd,
	input  logic [REG_ADDR_W-1:0]  in_rs1,
	input  logic [REG_ADDR_W-1:0]  in_rs2,
	input  logic [XLEN-1:0]        in_imm,
	input  logic                   in_use_imm,
	output logic                   retire_valid,
	output logic                   retire_wen,
	output logic [REG_ADDR_W-1:0]  retire_rd,
	output logic [XLEN-1:0]        retire_data
);

	logic [XLEN-1:0]       rs1_data;
	logic [XLEN-1:0]       rs2_data;
	logic [XLEN-1:0]       op_b;
	logic [XLEN-1:0]       alu_result;
	exec_op_t              st_op;
	logic [XLEN-1:0]       wdata;
	logic [STRB_W-1:0]     wstrb;
	logic [XLEN-1:0]       rdata;
	logic [XLEN-1:0]       load_data;
	exec_op_t              ex_op;
	logic [OFFS_W-1:0]     ex_offs;
	logic                  gpr_wen;
	logic [REG_ADDR_W-1:0] gpr_rd;
	logic [XLEN-1:0]       gpr_wdata;

	// operand b, immediate or rs2
	assign op_b = in_use_imm ? in_imm : rs2_data;
	// no store lanes without a valid op
	assign st_op = in_valid ? in_op : NOP;

	gpr_file u_gpr_file (
		.clk      (clk),
		.rst      (rst),
		.rs1      (in_rs1),
		.rs2      (in_rs2),
		.wen      (gpr_wen),
		.wr_rd    (gpr_rd),
		.wr_data  (gpr_wdata),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	alu_unit u_alu_unit (
		.op     (in_op),
		.a      (rs1_data),
		.b      (op_b),
		.result (alu_result)
	);

	// store side now, load side one cycle later
	lsu_align u_lsu_align (
		.st_op     (st_op),
		.st_offs   (alu_result[OFFS_W-1:0]),
		.st_src    (rs2_data),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.ld_op     (ex_op),
		.ld_offs   (ex_offs),
		.rdata     (rdata),
		.load_data (load_data)
	);

	// address wraps at 256 bytes
	data_ram u_data_ram (
		.clk   (clk),
		.addr  (alu_result[DMEM_ADDR_W-1:0]),
		.wdata (wdata),
		.wstrb (wstrb),
		.rdata (rdata)
	);

	writeback_stage u_writeback_stage (
		.clk          (clk),
		.rst          (rst),
		.valid        (in_valid),
		.op           (in_op),
		.rd           (in_rd),
		.alu_result   (alu_result),
		.st_data      (rs2_data),
		.load_data    (load_data),
		.ex_op        (ex_op),
		.ex_offs      (ex_offs),
		.gpr_wen      (gpr_wen),
		.gpr_rd       (gpr_rd),
		.gpr_wdata    (gpr_wdata),
		.retire_valid (retire_valid),
		.retire_wen   (retire_wen),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data)
	);

endmodule

`default_nettype wire

/* tb/rv_exec_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core_props
	import exec_pkg::*;
(
	input logic                   clk,
	input logic                   rst,
	input logic                   retire_valid,
	input logic                   retire_wen,
	input logic [REG_ADDR_W-1:0]  retire_rd,
	input logic [STRB_W-1:0]      wstrb
);

	// failed assertion count
	int fail_cnt = 0;

	// retire report quiet one edge after any reset edge
	assert property (@(posedge clk) rst |=> !retire_valid && !retire_wen)
		else begin
			$error("retire flags set right after reset");
			fail_cnt++;
		end

	// a register write is always part of a retired op
	assert property (@(posedge clk) disable iff (rst) retire_wen |-> retire_valid)
		else begin
			$error("retire_wen without retire_valid");
			fail_cnt++;
		end

	// x0 is never written
	assert property (@(posedge clk) disable iff (rst) retire_wen |-> retire_rd != '0)
		else begin
			$error("retire_wen set for rd 0");
			fail_cnt++;
		end

	// byte, half, word or double, each on its natural boundary
	assert property (@(posedge clk) disable iff (rst)
		wstrb != '0 |-> $onehot(wstrb) ||
			wstrb inside {8'h03, 8'h0c, 8'h30, 8'hc0, 8'h0f, 8'hf0, 8'hff})
		else begin
			$error("store strobes not naturally aligned: %b", wstrb);
			fail_cnt++;
		end

endmodule

`default_nettype wire

/* tb/tb_rv_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_exec_core
	import exec_pkg::*;
();

	localparam int RESET_CYCLES = 5;
	// x1..x31 loaded with random values, then every double word stored
	localparam int NUM_SETUP = 31;
	localparam int NUM_FILL = 32;
	localparam int NUM_RANDOM = 400;
	localparam int DRAIN_CYCLES = 10;
	// at most one idle cycle per op, plus drain margin
	localparam int MAX_CYCLES = RESET_CYCLES + (NUM_SETUP + NUM_FILL + NUM_RANDOM) * 2 + 50;

	logic                  clk;
	logic                  rst;
	logic                  in_valid;
	exec_op_t              in_op;
	logic [REG_ADDR_W-1:0] in_rd;
	logic [REG_ADDR_W-1:0] in_rs1;
	logic [REG_ADDR_W-1:0] in_rs2;
	logic [XLEN-1:0]       in_imm;
	logic                  in_use_imm;
	logic                  retire_valid;
	logic                  retire_wen;
	logic [REG_ADDR_W-1:0] retire_rd;
	logic [XLEN-1:0]       retire_data;

	// reference state
	logic [XLEN-1:0] model_regs [NUM_GPR];
	logic [7:0]      model_mem [256];

	// expected retire records, oldest first
	exec_op_t              exp_op_q[$];
	int                    exp_idx_q[$];
	logic                  exp_wen_q[$];
	logic [REG_ADDR_W-1:0] exp_rd_q[$];
	logic [XLEN-1:0]       exp_data_q[$];

	int seed;
	int op_count = 0;
	int cycle_cnt = 0;
	int n_checked = 0;
	int data_errs = 0;
	int flag_errs = 0;
	int order_errs = 0;
	int prop_errs = 0;

	rv_exec_core u_rv_exec_core (
		.clk          (clk),
		.rst          (rst),
		.in_valid     (in_valid),
		.in_op        (in_op),
		.in_rd        (in_rd),
		.in_rs1       (in_rs1),
		.in_rs2       (in_rs2),
		.in_imm       (in_imm),
		.in_use_imm   (in_use_imm),
		.retire_valid (retire_valid),
		.retire_wen   (retire_wen),
		.retire_rd    (retire_rd),
		.retire_data  (retire_data)
	);

	bind rv_exec_core rv_exec_core_props u_rv_exec_core_props (
		.clk          (clk),
		.rst          (rst),
		.retire_valid (retire_valid),
		.retire_wen   (retire_wen),
		.retire_rd    (retire_rd),
		.wstrb        (wstrb)
	);

	always #10 clk = ~clk;

	function automatic int rand_below(input int n);
		return {$random(seed)} % n;
	endfunction

	// short signed immediates mostly, full width sometimes
	function automatic logic [XLEN-1:0] rand_imm(input logic full);
		logic [31:0] lo;
		logic [31:0] hi;
		lo = $random(seed);
		hi = $random(seed);
		if (full || lo[31]) return {hi, lo};
		return {{52{lo[11]}}, lo[11:0]};
	endfunction

	function automatic logic [XLEN-1:0] sext_word(input logic [31:0] w);
		return {{32{w[31]}}, w};
	endfunction

	// rv64 integer rules
	function automatic logic [XLEN-1:0] ref_alu(input exec_op_t op,
		input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [31:0] aw;
		aw = a[31:0];
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			AND: return a & b;
			OR: return a | b;
			XOR: return a ^ b;
			SLL: return a << b[5:0];
			SRL: return a >> b[5:0];
			SRA: return $signed(a) >>> b[5:0];
			SLT: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			SLTU: return (a < b) ? 64'd1 : 64'd0;
			// word forms, 5-bit shift amount
			ADDW: return sext_word(aw + b[31:0]);
			SUBW: return sext_word(aw - b[31:0]);
			SLLW: return sext_word(aw << b[4:0]);
			SRLW: return sext_word(aw >> b[4:0]);
			SRAW: return sext_word($signed(aw) >>> b[4:0]);
			default: return 64'd0;
		endcase
	endfunction

	// bytes touched by a memory op
	function automatic int access_bytes(input exec_op_t op);
		case (op)
			LB, LBU, SB: return 1;
			LH, LHU, SH: return 2;
			LW, LWU, SW: return 4;
			default: return 8;
		endcase
	endfunction

	// little endian gather, then extend by opcode
	function automatic logic [XLEN-1:0] ref_load(input exec_op_t op, input logic [7:0] addr);
		logic [XLEN-1:0] v;
		v = '0;
		for (int k = 0; k < access_bytes(op); k++) begin
			v[k*8 +: 8] = model_mem[8'(addr + k)];
		end
		case (op)
			LB: v = {{56{v[7]}}, v[7:0]};
			LH: v = {{48{v[15]}}, v[15:0]};
			LW: v = sext_word(v[31:0]);
			default: ;
		endcase
		return v;
	endfunction

	// drive one op and queue its expected retire record
	task automatic issue_op(input exec_op_t op, input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [XLEN-1:0] imm, input logic use_imm);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] src;
		logic [XLEN-1:0] res;
		logic [7:0]      addr;
		logic            wen;
		@(posedge clk);
		#1;
		in_valid = 1'b1;
		in_op = op;
		in_rd = rd;
		in_rs1 = rs1;
		in_rs2 = rs2;
		in_imm = imm;
		in_use_imm = use_imm;
		a = model_regs[rs1];
		src = model_regs[rs2];
		b = use_imm ? imm : src;
		addr = 8'(a + b);
		if (op inside {SB, SH, SW, SD}) begin
			// retire reports the unshifted store data
			for (int k = 0; k < access_bytes(op); k++) begin
				model_mem[8'(addr + k)] = src[k*8 +: 8];
			end
			res = src;
			wen = 1'b0;
		end else if (op inside {LB, LH, LW, LBU, LHU, LWU, LD}) begin
			res = ref_load(op, addr);
			wen = (rd != 0);
		end else begin
			res = ref_alu(op, a, b);
			wen = (rd != 0);
		end
		if (wen) model_regs[rd] = res;
		exp_op_q.push_back(op);
		exp_idx_q.push_back(op_count);
		exp_wen_q.push_back(wen);
		exp_rd_q.push_back(rd);
		exp_data_q.push_back(res);
		op_count++;
	endtask

	task automatic idle_cycle();
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		in_op = NOP;
		in_use_imm = 1'b0;
	endtask

	task automatic check_retire();
		exec_op_t              op;
		int                    idx;
		logic                  wen;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       data;
		op = exp_op_q.pop_front();
		idx = exp_idx_q.pop_front();
		wen = exp_wen_q.pop_front();
		rd = exp_rd_q.pop_front();
		data = exp_data_q.pop_front();
		n_checked++;
		if (retire_wen !== wen) begin
			$display("** Error %s op %0d: retire_wen expected %0b, actual %0b",
				op.name(), idx, wen, retire_wen);
			flag_errs++;
		end
		if (retire_rd !== rd) begin
			$display("** Error %s op %0d: retire_rd expected %0d, actual %0d",
				op.name(), idx, rd, retire_rd);
			flag_errs++;
		end
		if (retire_data !== data) begin
			$display("** Error %s op %0d: retire_data expected %h, actual %h",
				op.name(), idx, data, retire_data);
			data_errs++;
		end
	endtask

	// retire outputs change at the rising edge, sampled mid cycle
	always @(negedge clk) begin
		if (!rst && retire_valid) begin
			if (exp_op_q.size() == 0) begin
				$display("retire_valid seen with no operation outstanding, cycle %0d",
					cycle_cnt);
				order_errs++;
			end else begin
				check_retire();
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("run stopped after %0d cycles, %0d retire records still pending",
				cycle_cnt, exp_op_q.size());
			$display("TB FAILED");
			$finish;
		end
	end

	initial begin
		exec_op_t        op;
		logic [4:0]      rd;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      last_rd;
		logic [XLEN-1:0] imm;
		logic            use_imm;
		int              n;
		seed = 32'h4985_9b00;
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_op = NOP;
		in_rd = '0;
		in_rs1 = '0;
		in_rs2 = '0;
		in_imm = '0;
		in_use_imm = 1'b0;
		last_rd = '0;
		for (int i = 0; i < NUM_GPR; i++) model_regs[i] = '0;
		for (int i = 0; i < 256; i++) model_mem[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// random values into x1..x31
		for (int r = 1; r <= NUM_SETUP; r++) begin
			issue_op(ADD, 5'(r), 5'd0, 5'd0, rand_imm(1'b1), 1'b1);
		end
		// whole ram written so every later load is defined
		for (int w = 0; w < NUM_FILL; w++) begin
			issue_op(SD, 5'd0, 5'd0, 5'(1 + w % 31), 64'(w * 8), 1'b1);
		end

		for (int i = 0; i < NUM_RANDOM; i++) begin
			// any opcode from ADD up to SD
			op = exec_op_t'(rand_below(26) + 1);
			rd = 5'(rand_below(32));
			rs2 = 5'(rand_below(32));
			// often depend on the op just before
			rs1 = (rand_below(4) == 0) ? last_rd : 5'(rand_below(32));
			use_imm = rand_below(2);
			imm = rand_imm(1'b0);
			if (op inside {LB, LH, LW, LBU, LHU, LWU, LD, SB, SH, SW, SD}) begin
				// base x0, aligned address below 256
				n = access_bytes(op);
				rs1 = '0;
				use_imm = 1'b1;
				imm = 64'(rand_below(256 / n) * n);
			end
			issue_op(op, rd, rs1, rs2, imm, use_imm);
			last_rd = rd;
			if (rand_below(3) == 0) idle_cycle();
		end
		idle_cycle();

		for (int i = 0; i < DRAIN_CYCLES && exp_op_q.size() != 0; i++) @(posedge clk);
		repeat (3) @(posedge clk);
		if (exp_op_q.size() != 0) begin
			$display("%0d issued operations never retired", exp_op_q.size());
			order_errs++;
		end
		prop_errs = u_rv_exec_core.u_rv_exec_core_props.fail_cnt;
		$display("retired %0d of %0d: data errors %0d, flag errors %0d, order errors %0d, %s %0d",
			n_checked, op_count, data_errs, flag_errs, order_errs, "property errors", prop_errs);
		if (data_errs + flag_errs + order_errs + prop_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rv_exec_core.f */
common/exec_pkg.sv
rtl/alu_unit.sv
lsu/lsu_align.sv
lsu/data_ram.sv
rtl/gpr_file.sv
rtl/writeback_stage.sv
rtl/rv_exec_core.sv
tb/rv_exec_core_props.sv
tb/tb_rv_exec_core.sv
